// ==== io_params.svh ====
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// bus geometry
`define IO_WIDTH 16
`define IO_SLOTS 4 // hardware slots in the core

// one-hot io address bits
`define IO_A_GPIO    0  // gpio data
`define IO_A_DIR     1  // gpio direction, 1 is output
`define IO_A_TASK1   8  // slot 1 token
`define IO_A_TASK2   9  // slot 2 token
`define IO_A_TASK3   10 // slot 3 token

// own task fetch on read
// kill request nibble on write
`define IO_A_TASKSEL 14

// slot id on read, mask set on write
`define IO_A_SLOT    15

`endif

// ==== io_pkg.sv ====
`default_nettype none

`include "io_params.svh"

package io_pkg;

  // one bus word, data or one-hot address
  typedef logic [`IO_WIDTH-1:0] io_word_t;

  // slot number as driven by the core
  typedef logic [$clog2(`IO_SLOTS)-1:0] slot_t;

  // one bit per slot
  typedef logic [`IO_SLOTS-1:0] slot_mask_t;

endpackage

`default_nettype wire

// ==== io_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// registered io access, one cycle behind the core
interface io_bus_if;

  logic             rd;    // read strobe
  logic             wr;    // write strobe
  io_pkg::io_word_t addr;  // one-hot, zero when idle
  io_pkg::io_word_t wdata; // write data
  io_pkg::slot_t    slot;  // slot that made the access
  io_pkg::io_word_t mask;  // mask of that slot

  // controller owns the stage
  modport ctrl (
    output rd, wr, addr, wdata, slot, mask
  );

  // devices only look at it
  modport dev (
    input rd, wr, addr, wdata, slot, mask
  );

endinterface

`default_nettype wire

// ==== io_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "io_params.svh"

module io_ctrl import io_pkg::*; (
  input  wire logic       clk,
  input  wire logic       resetq,
  // core side
  input  wire logic       io_rd,
  input  wire logic       io_wr,
  input  wire io_word_t   io_addr,
  input  wire slot_t      io_slot,
  input  wire io_word_t   io_wdata,
  output io_word_t        io_rdata,
  // registered stage to the devices
  io_bus_if.ctrl          bus,
  // device read words
  input  wire io_word_t   gpio_rd,
  input  wire io_word_t   dir_rd,
  input  wire io_word_t   [3:1] task_rd, // tokens of slots 1..3
  input  wire io_word_t   own_task
);

  logic     rd_q, wr_q;
  io_word_t addr_q;
  io_word_t wdata_q;
  slot_t    slot_q;

  io_word_t mask_q [`IO_SLOTS]; // one mask per slot
  io_word_t mask_cur;
  io_word_t rd_or;              // selected sources before masking

  // input stage, everything one cycle late
  always_ff @(posedge clk) begin
    if (!resetq) begin
      rd_q   <= 1'b0;
      wr_q   <= 1'b0;
      addr_q <= '0;
    end else begin
      rd_q <= io_rd;
      wr_q <= io_wr;
      // no strobe, no select
      addr_q <= (io_rd | io_wr) ? io_addr : '0;
    end
  end

  always_ff @(posedge clk) begin
    wdata_q <= io_wdata;
    slot_q  <= io_slot;
  end

  // mask lives for exactly one access of the same slot
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int s = 0; s < `IO_SLOTS; s++)
        mask_q[s] <= '1;
    end else if (rd_q | wr_q) begin
      if (wr_q & addr_q[`IO_A_SLOT])
        mask_q[slot_q] <= wdata_q; // armed for the next access
      else
        mask_q[slot_q] <= '1;      // used up, back to all ones
    end
  end

  assign mask_cur = mask_q[slot_q];

  // drive the shared stage
  assign bus.rd    = rd_q;
  assign bus.wr    = wr_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.slot  = slot_q;
  assign bus.mask  = mask_cur;

  // wired-or of every selected source
  always_comb begin
    rd_or = '0;
    if (addr_q[`IO_A_GPIO])
      rd_or |= gpio_rd;
    if (addr_q[`IO_A_DIR])
      rd_or |= dir_rd;
    for (int i = 1; i <= 3; i++) begin
      if (addr_q[`IO_A_TASK1 + i - 1])
        rd_or |= task_rd[i]; // raw token, bit 0 included
    end
    if (addr_q[`IO_A_TASKSEL])
      rd_or |= own_task;
    if (addr_q[`IO_A_SLOT])
      rd_or |= io_word_t'(slot_q); // zero extended slot id
  end

  // cleared mask bits read as zero
  assign io_rdata = rd_or & mask_cur;

endmodule

`default_nettype wire

// ==== gpio_port.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "io_params.svh"

module gpio_port import io_pkg::*; (
  input  wire logic     clk,
  input  wire logic     resetq,
  io_bus_if.dev         bus,
  // pins
  input  wire io_word_t gpio_in,
  output io_word_t      gpio_out,
  output io_word_t      gpio_oe,
  // read words
  output io_word_t      gpio_rd,
  output io_word_t      dir_rd
);

  io_word_t out_q;   // output data register
  io_word_t dir_q;   // 1 is output
  io_word_t out_nxt;
  io_word_t dir_nxt;

  logic we_out;
  logic we_dir;

  assign we_out = bus.wr & bus.addr[`IO_A_GPIO];
  assign we_dir = bus.wr & bus.addr[`IO_A_DIR];

  // masked bits from the core
  // the rest copied from the pins
  assign out_nxt = (bus.wdata & bus.mask) | (gpio_in & ~bus.mask);

  // masked bits change, others hold
  assign dir_nxt = (bus.wdata & bus.mask) | (dir_q & ~bus.mask);

  always_ff @(posedge clk) begin
    if (!resetq) begin
      out_q <= '0;
      dir_q <= '0; // all pins input
    end else begin
      if (we_out)
        out_q <= out_nxt;
      if (we_dir)
        dir_q <= dir_nxt;
    end
  end

  assign gpio_out = out_q;
  assign gpio_oe  = dir_q;

  // pin level is what the core reads back
  assign gpio_rd = gpio_in;
  assign dir_rd  = dir_q;

endmodule

`default_nettype wire

// ==== task_table.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "io_params.svh"

module task_table import io_pkg::*; (
  input  wire logic clk,
  input  wire logic resetq,
  io_bus_if.dev     bus,
  // read words
  output io_word_t  [3:1] task_rd,
  output io_word_t  own_task,
  // to the core scheduler
  output slot_mask_t kill_slots,
  output io_word_t  task_xt_slot1,
  output io_word_t  task_xt_slot2,
  output io_word_t  task_xt_slot3
);

  io_word_t   xt_q [3:1]; // slot 0 has no token
  slot_mask_t kill_q;
  io_word_t   own_raw;    // token of the accessing slot
  logic       fetch;      // own task read

  assign fetch = bus.rd & bus.addr[`IO_A_TASKSEL];

  // select the accessing slot's token
  always_comb begin
    case (bus.slot)
      2'd1:    own_raw = xt_q[1];
      2'd2:    own_raw = xt_q[2];
      2'd3:    own_raw = xt_q[3];
      default: own_raw = '0; // slot 0 always starts from zero
    endcase
  end

  // valid xts are even, bit 0 is the run once flag
  assign own_task = {own_raw[`IO_WIDTH-1:1], 1'b0};

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 1; i <= 3; i++)
        xt_q[i] <= '0;
      kill_q <= '0;
    end else if (bus.wr) begin
      // any slot may set any token, several at once
      for (int i = 1; i <= 3; i++) begin
        if (bus.addr[`IO_A_TASK1 + i - 1])
          xt_q[i] <= bus.wdata;
      end
      // kill nibble only on a tasksel write
      kill_q <= bus.addr[`IO_A_TASKSEL] ? bus.wdata[`IO_SLOTS-1:0] : '0;
    end else if (fetch && bus.slot != '0) begin
      // run once tokens clear after their own fetch
      if (own_raw[0])
        xt_q[bus.slot] <= '0;
    end
  end

  always_comb begin
    for (int i = 1; i <= 3; i++)
      task_rd[i] = xt_q[i]; // raw tokens for the task addresses
  end

  assign kill_slots    = kill_q;
  assign task_xt_slot1 = xt_q[1];
  assign task_xt_slot2 = xt_q[2];
  assign task_xt_slot3 = xt_q[3];

endmodule

`default_nettype wire

// ==== io_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

module io_subsys import io_pkg::*; (
  input  wire logic       clk,
  input  wire logic       resetq,
  // core io bus
  input  wire logic       io_rd,
  input  wire logic       io_wr,
  input  wire io_word_t   io_addr,
  input  wire slot_t      io_slot,
  input  wire io_word_t   io_wdata,
  output io_word_t        io_rdata,
  // gpio pins, pad split into out, oe and in
  output io_word_t        gpio_out,
  output io_word_t        gpio_oe,
  input  wire io_word_t   gpio_in,
  // task scheduler side
  output slot_mask_t      kill_slots,
  output io_word_t        task_xt_slot1,
  output io_word_t        task_xt_slot2,
  output io_word_t        task_xt_slot3
);

  io_bus_if bus0 (); // registered stage

  io_word_t       gpio_rd;
  io_word_t       dir_rd;
  io_word_t [3:1] task_rd;
  io_word_t       own_task;

  io_ctrl ctrl0 (
    .clk      (clk),
    .resetq   (resetq),
    .io_rd    (io_rd),
    .io_wr    (io_wr),
    .io_addr  (io_addr),
    .io_slot  (io_slot),
    .io_wdata (io_wdata),
    .io_rdata (io_rdata),
    .bus      (bus0.ctrl),
    .gpio_rd  (gpio_rd),
    .dir_rd   (dir_rd),
    .task_rd  (task_rd),
    .own_task (own_task)
  );

  gpio_port gpio0 (
    .clk      (clk),
    .resetq   (resetq),
    .bus      (bus0.dev),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .gpio_rd  (gpio_rd),
    .dir_rd   (dir_rd)
  );

  task_table task0 (
    .clk           (clk),
    .resetq        (resetq),
    .bus           (bus0.dev),
    .task_rd       (task_rd),
    .own_task      (own_task),
    .kill_slots    (kill_slots),
    .task_xt_slot1 (task_xt_slot1),
    .task_xt_slot2 (task_xt_slot2),
    .task_xt_slot3 (task_xt_slot3)
  );

endmodule

`default_nettype wire

// ==== tb_io_model.svh ====
`ifndef TB_IO_MODEL_SVH
`define TB_IO_MODEL_SVH

// testbench copy of the register state
io_word_t   m_pins;                   // level driven on gpio_in
io_word_t   m_out;
io_word_t   m_dir;                    // 1 is output
io_word_t   m_tok  [1:3];             // tokens of slots 1..3
io_word_t   m_mask [0:`IO_SLOTS-1];
slot_mask_t m_kill;

// expected read words, oldest first
io_word_t exp_q  [$];
string    name_q [$];

function automatic io_word_t rand_word();
  logic [31:0] r;
  r = $random(seed);
  return r[`IO_WIDTH-1:0];
endfunction

// state right after reset
task automatic clear_model();
  m_pins = gpio_in;
  m_out  = '0;
  m_dir  = '0;
  m_kill = '0;
  for (int i = 1; i <= 3; i++)
    m_tok[i] = '0;
  for (int i = 0; i < `IO_SLOTS; i++)
    m_mask[i] = '1;
endtask

// OR of every selected source, then the slot's mask
function automatic io_word_t exp_rdata(input io_word_t addr, input slot_t s);
  io_word_t w;
  w = '0;
  if (addr[`IO_A_GPIO])
    w = w | m_pins; // pins, not the output register
  if (addr[`IO_A_DIR])
    w = w | m_dir;
  for (int i = 1; i <= 3; i++) begin
    if (addr[`IO_A_TASK1 + i - 1])
      w = w | m_tok[i];
  end
  if (addr[`IO_A_TASKSEL] && s != 2'd0)
    w = w | {m_tok[s][`IO_WIDTH-1:1], 1'b0}; // run once flag hidden
  if (addr[`IO_A_SLOT])
    w = w | {{(`IO_WIDTH-$bits(slot_t)){1'b0}}, s};
  return w & m_mask[s];
endfunction

// one write, strobe held for a single cycle
task automatic write_access(input slot_t s, input io_word_t addr, input io_word_t d);
  io_word_t mk;
  @(posedge clk);
  #1;
  io_wr    = 1'b1;
  io_rd    = 1'b0;
  io_addr  = addr;
  io_slot  = s;
  io_wdata = d;
  mk = m_mask[s];
  if (addr[`IO_A_GPIO])
    m_out = (d & mk) | (m_pins & ~mk);
  if (addr[`IO_A_DIR])
    m_dir = (d & mk) | (m_dir & ~mk); // unmasked bits hold
  for (int i = 1; i <= 3; i++) begin
    if (addr[`IO_A_TASK1 + i - 1])
      m_tok[i] = d;
  end
  m_kill    = addr[`IO_A_TASKSEL] ? d[`IO_SLOTS-1:0] : '0;
  m_mask[s] = addr[`IO_A_SLOT] ? d : '1; // armed or used up
  @(posedge clk);
  #1;
  io_wr   = 1'b0;
  io_addr = '0;
endtask

// one read, expected word queued for the checker
task automatic read_access(input slot_t s, input io_word_t addr, input string what);
  @(posedge clk);
  #1;
  io_rd   = 1'b1;
  io_wr   = 1'b0;
  io_addr = addr;
  io_slot = s;
  exp_q.push_back(exp_rdata(addr, s)); // before side effects
  name_q.push_back(what);
  if (addr[`IO_A_TASKSEL] && s != 2'd0 && m_tok[s][0])
    m_tok[s] = '0; // run once token gone after its fetch
  m_mask[s] = '1;
  @(posedge clk);
  #1;
  io_rd   = 1'b0;
  io_addr = '0;
endtask

`endif

// ==== tb_io_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "io_params.svh"

module tb_io_subsys import io_pkg::*; ();

  localparam int CLK_NS   = 4;
  localparam int N_GPIO   = 8;
  localparam int N_DIR    = 8;
  localparam int N_KILL   = 4;
  // total bus accesses over all sections
  localparam int N_ACCESS = 2 + 3*N_GPIO + 3*N_DIR + 12 + 15 + 2*N_KILL;
  localparam int TIMEOUT_CYC = 3*N_ACCESS + 100; // margin for settles

  localparam io_word_t A_GPIO    = io_word_t'(1 << `IO_A_GPIO);
  localparam io_word_t A_DIR     = io_word_t'(1 << `IO_A_DIR);
  localparam io_word_t A_TASK1   = io_word_t'(1 << `IO_A_TASK1);
  localparam io_word_t A_TASK2   = io_word_t'(1 << `IO_A_TASK2);
  localparam io_word_t A_TASK3   = io_word_t'(1 << `IO_A_TASK3);
  localparam io_word_t A_TASKSEL = io_word_t'(1 << `IO_A_TASKSEL);
  localparam io_word_t A_SLOT    = io_word_t'(1 << `IO_A_SLOT);

  logic       clk;
  logic       resetq;
  logic       io_rd;
  logic       io_wr;
  io_word_t   io_addr;
  slot_t      io_slot;
  io_word_t   io_wdata;
  io_word_t   io_rdata;
  io_word_t   gpio_out;
  io_word_t   gpio_oe;
  io_word_t   gpio_in;
  slot_mask_t kill_slots;
  io_word_t   task_xt_slot1;
  io_word_t   task_xt_slot2;
  io_word_t   task_xt_slot3;

  integer seed;
  int     n_checks = 0;
  int     n_errors = 0;
  logic   rd_seen  = 1'b0; // read presented last cycle

  io_subsys dut0 (
    .clk           (clk),
    .resetq        (resetq),
    .io_rd         (io_rd),
    .io_wr         (io_wr),
    .io_addr       (io_addr),
    .io_slot       (io_slot),
    .io_wdata      (io_wdata),
    .io_rdata      (io_rdata),
    .gpio_out      (gpio_out),
    .gpio_oe       (gpio_oe),
    .gpio_in       (gpio_in),
    .kill_slots    (kill_slots),
    .task_xt_slot1 (task_xt_slot1),
    .task_xt_slot2 (task_xt_slot2),
    .task_xt_slot3 (task_xt_slot3)
  );

  task automatic check_word(input string what, input io_word_t exp, input io_word_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error %s: expected %h, actual %h", what, exp, act);
    end
  endtask

  function automatic io_word_t kill_word(input slot_mask_t k);
    return {{(`IO_WIDTH-`IO_SLOTS){1'b0}}, k};
  endfunction

  task automatic print_summary();
    $display("checks %0d, errors %0d", n_checks, n_errors);
  endtask

  `include "tb_io_model.svh"

  task automatic set_pins(input io_word_t v);
    @(posedge clk);
    #1;
    gpio_in = v;
    m_pins  = v;
  endtask

  // let a registered write land
  task automatic settle();
    @(posedge clk);
    #1;
  endtask

  task automatic reset_state_check();
    check_word("reset gpio_oe", '0, gpio_oe);
    check_word("reset gpio_out", '0, gpio_out);
    check_word("reset kill_slots", '0, kill_word(kill_slots));
    check_word("reset task_xt_slot1", '0, task_xt_slot1);
    check_word("reset task_xt_slot2", '0, task_xt_slot2);
    check_word("reset task_xt_slot3", '0, task_xt_slot3);
    read_access(2'd0, A_DIR, "reset dir read");
    read_access(2'd0, A_GPIO, "reset gpio read"); // just the pins
  endtask

  task automatic gpio_data_writes();
    io_word_t mk;
    io_word_t d;
    io_word_t r;
    slot_t    s;
    for (int i = 0; i < N_GPIO; i++) begin
      r  = rand_word();
      s  = r[1:0];
      mk = rand_word();
      d  = rand_word();
      set_pins(rand_word());
      write_access(s, A_SLOT, mk);
      write_access(s, A_GPIO, d);
      settle();
      // model merges data and pin bits under the mask
      check_word($sformatf("gpio data %0d", i), m_out, gpio_out);
      read_access(s, A_GPIO, $sformatf("gpio mask cleared %0d", i)); // unmasked now
    end
  endtask

  task automatic gpio_dir_writes();
    io_word_t mk;
    io_word_t d;
    io_word_t prev;
    io_word_t r;
    slot_t    s;
    for (int i = 0; i < N_DIR; i++) begin
      r    = rand_word();
      s    = r[1:0];
      mk   = rand_word();
      d    = rand_word();
      prev = m_dir;
      write_access(s, A_SLOT, mk);
      write_access(s, A_DIR, d);
      settle();
      check_word($sformatf("gpio dir %0d", i), (d & mk) | (prev & ~mk), gpio_oe);
      read_access(s, A_DIR, $sformatf("dir read back %0d", i));
    end
  endtask

  task automatic slot_id_masks();
    set_pins(rand_word());
    for (int s = 0; s < `IO_SLOTS; s++)
      read_access(slot_t'(s), A_SLOT, $sformatf("slot id %0d", s));
    // arm all four masks before any is used
    for (int s = 0; s < `IO_SLOTS; s++)
      write_access(slot_t'(s), A_SLOT, rand_word());
    for (int s = `IO_SLOTS - 1; s >= 0; s--)
      read_access(slot_t'(s), A_GPIO, $sformatf("masked gpio slot %0d", s));
  endtask

  task automatic task_fetch_runs();
    io_word_t w;
    io_word_t t1;
    io_word_t t2;
    io_word_t t3;
    w  = rand_word();
    t1 = rand_word() | 16'h0001; // run once
    t2 = rand_word() & 16'hfffe; // stays
    t3 = rand_word() | 16'h0001; // run once
    write_access(2'd0, A_TASK1 | A_TASK2 | A_TASK3, w); // all tokens at once
    settle();
    check_word("token all 1", w, task_xt_slot1);
    check_word("token all 2", w, task_xt_slot2);
    check_word("token all 3", w, task_xt_slot3);
    write_access(2'd2, A_TASK1, t1); // foreign slots write
    write_access(2'd3, A_TASK2, t2);
    write_access(2'd1, A_TASK3, t3);
    read_access(2'd0, A_TASK1, "raw token 1");
    read_access(2'd0, A_TASK2, "raw token 2");
    read_access(2'd0, A_TASK3, "raw token 3");
    for (int pass = 0; pass < 2; pass++) begin
      for (int s = 0; s < `IO_SLOTS; s++)
        read_access(slot_t'(s), A_TASKSEL, $sformatf("task fetch %0d slot %0d", pass, s));
      settle();
      check_word($sformatf("task_xt_slot1 pass %0d", pass), '0, task_xt_slot1);
      check_word($sformatf("task_xt_slot2 pass %0d", pass), t2, task_xt_slot2);
      check_word($sformatf("task_xt_slot3 pass %0d", pass), '0, task_xt_slot3);
    end
  endtask

  task automatic kill_requests();
    io_word_t d;
    io_word_t r;
    slot_t    s;
    for (int i = 0; i < N_KILL; i++) begin
      r = rand_word();
      s = r[1:0];
      d = rand_word();
      write_access(s, A_TASKSEL, d);
      settle();
      check_word($sformatf("kill nibble %0d", i), kill_word(m_kill), kill_word(kill_slots));
      write_access(s, A_GPIO, rand_word()); // any other write drops it
      settle();
      check_word($sformatf("kill cleared %0d", i), kill_word(m_kill), kill_word(kill_slots));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_NS/2) clk = ~clk;
  end

  // read data sits on io_rdata the cycle after the read
  always @(negedge clk) begin : rd_check
    io_word_t e;
    string    nm;
    if (rd_seen) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("read data came back but no expected value was queued");
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        check_word(nm, e, io_rdata);
      end
    end
    rd_seen = io_rd;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYC);
    print_summary();
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed     = 32'h890b;
    resetq   = 1'b0;
    io_rd    = 1'b0;
    io_wr    = 1'b0;
    io_addr  = '0;
    io_slot  = '0;
    io_wdata = '0;
    gpio_in  = rand_word();
    clear_model();
    repeat (2) @(posedge clk);
    #1;
    resetq = 1'b1;
    reset_state_check();
    gpio_data_writes();
    gpio_dir_writes();
    slot_id_masks();
    task_fetch_runs();
    kill_requests();
    repeat (3) @(posedge clk); // last read reaches the checker
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d reads were never checked", exp_q.size());
    end
    print_summary();
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== io_subsys.f ====
+incdir+.
io_pkg.sv
io_bus_if.sv
io_ctrl.sv
gpio_port.sv
task_table.sv
io_subsys.sv
tb_io_subsys.sv

// ==== Makefile ====
# verilator run of the io subsystem testbench

TOP = tb_io_subsys

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run, decide pass or fail from sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -f io_subsys.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TESTBENCH PASSED" sim.log; then \
	  echo "result: pass"; \
	else \
	  echo "result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
